// File: flist.f
src/isa_pkg.sv
src/ooo_pkg.sv
src/issue_stage.sv
src/operand_read.sv
src/add_sub_station.sv
src/mov_station.sv
src/result_bus.sv
src/reorder_buffer.sv
src/core_top.sv
bench/core_properties.sv
bench/tb_core.sv

// File: bench/tb_core.sv
`timescale 1ns/1ps

module tb_core
	import isa_pkg::*;
	import ooo_pkg::*;
();

	logic     clk;
	logic     rst_n;
	logic     inst_valid;
	inst_t    inst;
	logic     inst_ready;
	commit_t  commit;

	integer   seed;
	int       errors;
	int       accepts;
	int       commits;
	data_t    model_regs [NUM_REGS];
	reg_num_t exp_rd [$];
	data_t    exp_data [$];

	core_top u_dut (.clk, .rst_n, .inst_valid, .inst, .inst_ready, .commit);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic int unsigned pick(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic inst_t rand_inst(input op_t op, input int unsigned lo,
	                                    input int unsigned span);
		inst_t i;
		i.op  = op;
		i.rd  = reg_num_t'(lo + pick(span));
		i.rs1 = reg_num_t'(lo + pick(span));
		i.rs2 = reg_num_t'(lo + pick(span));
		i.imm = imm_t'($random(seed));
		return i;
	endfunction

	task automatic finish_run();
		$display("errors: %0d, accepted: %0d, committed: %0d", errors, accepts, commits);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////////////////////////
	// sequential model and commit checks
	//////////////////////////////////////////////////////////////////////

	task automatic record_accept(input inst_t i);
		data_t a;
		data_t b;
		data_t res;
		a = model_regs[i.rs1];
		b = model_regs[i.rs2];
		case (i.op)
			OP_ADD:  res = a + b;
			OP_SUB:  res = a - b;
			OP_MOV:  res = a;
			default: res = a + {{16{i.imm[15]}}, i.imm};
		endcase
		model_regs[i.rd] = res;
		exp_rd.push_back(i.rd);
		exp_data.push_back(res);
		accepts++;
	endtask

	task automatic check_commit();
		reg_num_t rd;
		data_t    d;
		commits++;
		if (exp_rd.size() == 0) begin
			$display("commit at %0t with no accepted instruction outstanding", $time);
			errors++;
		end else begin
			rd = exp_rd.pop_front();
			d  = exp_data.pop_front();
			if (commit.rd !== rd) begin
				$display("ERR %0t commit.rd expected %0d got %0d", $time, rd, commit.rd);
				errors++;
			end
			if (commit.data !== d) begin
				$display("ERR %0t commit.data expected %h got %h", $time, d, commit.data);
				errors++;
			end
		end
	endtask

	// sampled mid-cycle, commits before this cycle's acceptance
	always @(negedge clk) begin
		if (accepts == 0 && commit.valid !== 1'b0) begin
			$display("ERR %0t commit.valid expected 0 got %b", $time, commit.valid);
			errors++;
		end else if (commit.valid === 1'b1) begin
			check_commit();
		end
		if (inst_valid === 1'b1 && inst_ready === 1'b1) begin
			record_accept(inst);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	// holds the instruction until it is taken
	task automatic send_inst(input inst_t i);
		int waited;
		inst_valid = 1'b1;
		inst       = i;
		waited     = 0;
		@(negedge clk);
		while (inst_ready !== 1'b1 && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (inst_ready !== 1'b1) begin
			$display("timeout at %0t: inst_ready stayed low for 100 cycles", $time);
			errors++;
			finish_run();
		end
		@(posedge clk);
		#2;
	endtask

	task automatic idle_cycles(input int unsigned n);
		inst_valid = 1'b0;
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic wait_drain();
		int waited;
		inst_valid = 1'b0;
		waited     = 0;
		while (commits != accepts && waited < 200) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (commits != accepts) begin
			$display("timeout at %0t: %0d of %0d accepted instructions never committed",
			         $time, accepts - commits, accepts);
			errors++;
			finish_run();
		end
	endtask

	initial begin
		seed       = 32'hf6ed_b073;
		errors     = 0;
		accepts    = 0;
		commits    = 0;
		rst_n      = 1'b0;
		inst_valid = 1'b0;
		inst       = '0;
		for (int r = 0; r < NUM_REGS; r++) begin
			model_regs[r] = '0;
		end
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		@(negedge clk);
		if (inst_ready !== 1'b1) begin
			$display("ERR %0t inst_ready expected 1 got %b", $time, inst_ready);
			errors++;
		end
		@(posedge clk);
		#2;

		// isolated MOV and ADDI
		for (int n = 0; n < 40; n++) begin
			send_inst(rand_inst(pick(2) ? OP_ADDI : OP_MOV, 0, NUM_REGS));
			wait_drain();
		end

		// ADD/SUB chains on four registers
		for (int n = 0; n < 100; n++) begin
			send_inst(rand_inst(pick(2) ? OP_SUB : OP_ADD, 0, 4));
			idle_cycles(pick(3));
		end
		wait_drain();

		// independent pairs, low and high register halves
		for (int n = 0; n < 40; n++) begin
			send_inst(rand_inst(OP_ADD, 0, 4));
			send_inst(rand_inst(OP_MOV, 4, 4));
			idle_cycles(pick(4));
		end
		wait_drain();

		// valid held high, fills stations and rob
		for (int n = 0; n < 80; n++) begin
			send_inst(rand_inst(op_t'(pick(4)), 0, NUM_REGS));
		end
		wait_drain();

		if (exp_rd.size() != 0) begin
			$display("model queue still holds %0d entries after drain", exp_rd.size());
			errors++;
		end
		finish_run();
	end

endmodule

// File: bench/core_properties.sv
`timescale 1ns/1ps

module rob_properties
	import ooo_pkg::*;
(
	input logic                 clk,
	input logic                 rst_n,
	input logic [TAG_W:0]       count,
	input logic [ROB_DEPTH-1:0] busy,
	input logic [ROB_DEPTH-1:0] done,
	input cdb_t                 cdb,
	input commit_t              retire,
	input tag_t                 retire_tag
);

	// occupancy bound
	count_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		count <= ROB_DEPTH)
		else $error("rob count %0d above depth", count);

	// one pulse per retired slot
	single_retire: assert property (@(posedge clk) disable iff (!rst_n)
		retire.valid |=> !(retire.valid && retire_tag == $past(retire_tag)))
		else $error("retire held high on tag %0d", retire_tag);

	// results only for slots still waiting
	cdb_target: assert property (@(posedge clk) disable iff (!rst_n)
		cdb.valid |-> busy[cdb.tag] && !done[cdb.tag])
		else $error("cdb names slot %0d that is not waiting", cdb.tag);

endmodule

bind reorder_buffer rob_properties u_props (
	.clk, .rst_n, .count, .busy, .done, .cdb, .retire, .retire_tag
);

// File: src/core_top.sv
`timescale 1ns/1ps

module core_top
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    inst_valid,
	input  inst_t   inst,
	output logic    inst_ready,
	output commit_t commit
);

	dispatch_t dispatch;
	reg_num_t  rs1;
	reg_num_t  rs2;
	operand_t  src_a;
	operand_t  src_b;
	tag_t      rob_tag_a;
	tag_t      rob_tag_b;
	operand_t  rob_a;
	operand_t  rob_b;
	logic      rob_free;
	cdb_t      cdb;
	tag_t      retire_tag;
	logic      add_sub_busy;
	logic      add_sub_req;
	logic      add_sub_grant;
	tag_t      add_sub_tag;
	data_t     add_sub_result;
	logic      mov_busy;
	logic      mov_req;
	logic      mov_grant;
	tag_t      mov_tag;
	data_t     mov_result;

	issue_stage u_issue (
		.clk, .rst_n, .inst_valid, .inst, .rob_free, .add_sub_busy, .mov_busy,
		.add_sub_grant, .mov_grant, .src_a, .src_b, .inst_ready, .rs1, .rs2, .dispatch
	);

	operand_read u_read (
		.clk, .rst_n, .rs1, .rs2, .dispatch, .cdb, .retire(commit), .retire_tag,
		.rob_a, .rob_b, .rob_tag_a, .rob_tag_b, .src_a, .src_b
	);

	add_sub_station u_add_sub (
		.clk, .rst_n, .dispatch, .cdb, .grant(add_sub_grant),
		.busy(add_sub_busy), .req(add_sub_req), .tag(add_sub_tag), .result(add_sub_result)
	);

	mov_station u_mov (
		.clk, .rst_n, .dispatch, .cdb, .grant(mov_grant),
		.busy(mov_busy), .req(mov_req), .tag(mov_tag), .result(mov_result)
	);

	result_bus u_bus (
		.add_sub_req, .add_sub_tag, .add_sub_result, .mov_req, .mov_tag, .mov_result,
		.add_sub_grant, .mov_grant, .cdb
	);

	// retire doubles as the commit output
	reorder_buffer u_rob (
		.clk, .rst_n, .dispatch, .cdb, .rob_tag_a, .rob_tag_b,
		.rob_free, .rob_a, .rob_b, .retire(commit), .retire_tag
	);

endmodule

// File: src/reorder_buffer.sv
`timescale 1ns/1ps

module reorder_buffer
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  tag_t      rob_tag_a,
	input  tag_t      rob_tag_b,
	output logic      rob_free,
	output operand_t  rob_a,
	output operand_t  rob_b,
	output commit_t   retire,
	output tag_t      retire_tag
);

	logic     [ROB_DEPTH-1:0] busy;
	logic     [ROB_DEPTH-1:0] done;
	reg_num_t                 rd_q [ROB_DEPTH];
	data_t                    data_q [ROB_DEPTH];
	tag_t                     head;
	logic     [TAG_W:0]       count;

	logic  retire_now;
	data_t head_data;
	logic  ret_valid;
	reg_num_t ret_rd;
	data_t ret_data;

	assign rob_free = (count < ROB_DEPTH);

	// done is kept past retire so lookups stay valid until the file is written
	assign rob_a = '{ready: done[rob_tag_a], tag: rob_tag_a, data: data_q[rob_tag_a]};
	assign rob_b = '{ready: done[rob_tag_b], tag: rob_tag_b, data: data_q[rob_tag_b]};

	// head may retire straight off the bus
	assign retire_now = busy[head] && (done[head] || (cdb.valid && cdb.tag == head));
	assign head_data  = done[head] ? data_q[head] : cdb.data;

	//////////////////////////////////////////////////////////////////////
	// slot state, head and occupancy
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= '0;
			done      <= '0;
			head      <= '0;
			count     <= '0;
			ret_valid <= 1'b0;
		end else begin
			if (dispatch.valid) begin
				busy[dispatch.tag] <= 1'b1;
				done[dispatch.tag] <= 1'b0;
			end
			if (cdb.valid) begin
				done[cdb.tag] <= 1'b1;
			end
			if (retire_now) begin
				busy[head] <= 1'b0;
				head       <= next_tag(head);
			end
			case ({dispatch.valid, retire_now})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			ret_valid <= retire_now;
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch.valid) begin
			rd_q[dispatch.tag] <= dispatch.rd;
		end
		if (cdb.valid) begin
			data_q[cdb.tag] <= cdb.data;
		end
		if (retire_now) begin
			ret_rd     <= rd_q[head];
			ret_data   <= head_data;
			retire_tag <= head;
		end
	end

	assign retire = '{valid: ret_valid, rd: ret_rd, data: ret_data};

endmodule

// File: src/result_bus.sv
`timescale 1ns/1ps

module result_bus
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic  add_sub_req,
	input  tag_t  add_sub_tag,
	input  data_t add_sub_result,
	input  logic  mov_req,
	input  tag_t  mov_tag,
	input  data_t mov_result,
	output logic  add_sub_grant,
	output logic  mov_grant,
	output cdb_t  cdb
);

	// fixed priority, add/sub first
	assign add_sub_grant = add_sub_req;
	assign mov_grant     = mov_req && !add_sub_req;

	always_comb begin
		cdb.valid = add_sub_req || mov_req;
		if (add_sub_req) begin
			cdb.tag  = add_sub_tag;
			cdb.data = add_sub_result;
		end else begin
			cdb.tag  = mov_tag;
			cdb.data = mov_result;
		end
	end

endmodule

// File: src/mov_station.sv
`timescale 1ns/1ps

module mov_station
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  logic      grant,
	output logic      busy,
	output logic      req,
	output tag_t      tag,
	output data_t     result
);

	logic     valid;
	logic     is_addi;
	tag_t     entry_tag;
	imm_t     imm;
	operand_t a;
	logic     capture;

	assign capture = dispatch.valid && (dispatch.op == OP_MOV || dispatch.op == OP_ADDI);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (capture) begin
			valid <= 1'b1;
		end else if (grant) begin
			valid <= 1'b0;
		end
	end

	// only src_a matters here
	always_ff @(posedge clk) begin
		if (capture) begin
			entry_tag <= dispatch.tag;
			is_addi   <= (dispatch.op == OP_ADDI);
			imm       <= dispatch.imm;
			a         <= dispatch.src_a;
		end else begin
			a <= snoop(a, cdb);
		end
	end

	assign busy = valid;
	assign req  = valid && a.ready;
	assign tag  = entry_tag;

	assign result = is_addi ? (a.data + sext(imm)) : a.data;

endmodule

// File: src/add_sub_station.sv
`timescale 1ns/1ps

module add_sub_station
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  logic      grant,
	output logic      busy,
	output logic      req,
	output tag_t      tag,
	output data_t     result
);

	logic     valid;
	logic     is_sub;
	tag_t     entry_tag;
	operand_t a;
	operand_t b;
	logic     capture;

	assign capture = dispatch.valid && (dispatch.op == OP_ADD || dispatch.op == OP_SUB);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else if (capture) begin
			valid <= 1'b1;
		end else if (grant) begin
			valid <= 1'b0;
		end
	end

	// operands wait here until the bus delivers them
	always_ff @(posedge clk) begin
		if (capture) begin
			entry_tag <= dispatch.tag;
			is_sub    <= (dispatch.op == OP_SUB);
			a         <= dispatch.src_a;
			b         <= dispatch.src_b;
		end else begin
			a <= snoop(a, cdb);
			b <= snoop(b, cdb);
		end
	end

	assign busy = valid;
	assign req  = valid && a.ready && b.ready;
	assign tag  = entry_tag;

	// wraps at 32 bits
	assign result = is_sub ? (a.data - b.data) : (a.data + b.data);

endmodule

// File: src/operand_read.sv
`timescale 1ns/1ps

module operand_read
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  reg_num_t  rs1,
	input  reg_num_t  rs2,
	input  dispatch_t dispatch,
	input  cdb_t      cdb,
	input  commit_t   retire,
	input  tag_t      retire_tag,
	input  operand_t  rob_a,
	input  operand_t  rob_b,
	output tag_t      rob_tag_a,
	output tag_t      rob_tag_b,
	output operand_t  src_a,
	output operand_t  src_b
);

	data_t                regs [NUM_REGS];
	logic  [NUM_REGS-1:0] pending;
	tag_t                 ptag [NUM_REGS];

	// arch file, then bus, then rob, else wait on the pending tag
	function automatic operand_t resolve(input reg_num_t r, input operand_t rob);
		operand_t o;
		o.tag = ptag[r];
		if (!pending[r]) begin
			o.ready = 1'b1;
			o.data  = regs[r];
		end else if (cdb.valid && cdb.tag == ptag[r]) begin
			o.ready = 1'b1;
			o.data  = cdb.data;
		end else if (rob.ready) begin
			o.ready = 1'b1;
			o.data  = rob.data;
		end else begin
			o.ready = 1'b0;
			o.data  = '0;
		end
		return o;
	endfunction

	assign rob_tag_a = ptag[rs1];
	assign rob_tag_b = ptag[rs2];

	always_comb begin
		src_a = resolve(rs1, rob_a);
		src_b = resolve(rs2, rob_b);
	end

	//////////////////////////////////////////////////////////////////////
	// register state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending <= '0;
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
				ptag[i] <= '0;
			end
		end else begin
			if (retire.valid) begin
				regs[retire.rd] <= retire.data;
				// only the newest producer releases the register
				if (ptag[retire.rd] == retire_tag) begin
					pending[retire.rd] <= 1'b0;
				end
			end
			// a new producer in the same cycle keeps it pending
			if (dispatch.valid) begin
				pending[dispatch.rd] <= 1'b1;
				ptag[dispatch.rd]    <= dispatch.tag;
			end
		end
	end

endmodule

// File: src/issue_stage.sv
`timescale 1ns/1ps

module issue_stage
	import isa_pkg::*;
	import ooo_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  logic      inst_valid,
	input  inst_t     inst,
	input  logic      rob_free,
	input  logic      add_sub_busy,
	input  logic      mov_busy,
	input  logic      add_sub_grant,
	input  logic      mov_grant,
	input  operand_t  src_a,
	input  operand_t  src_b,
	output logic      inst_ready,
	output reg_num_t  rs1,
	output reg_num_t  rs2,
	output dispatch_t dispatch
);

	tag_t tail;
	logic to_add_sub;
	logic station_free;
	logic accept;

	assign to_add_sub = (inst.op == OP_ADD) || (inst.op == OP_SUB);

	// a station being granted this cycle is empty at the next edge
	assign station_free = to_add_sub ? (!add_sub_busy || add_sub_grant)
	                                 : (!mov_busy || mov_grant);

	assign inst_ready = rst_n && rob_free && station_free;
	assign accept     = inst_valid && inst_ready;

	// register numbers go straight to the read stage
	assign rs1 = inst.rs1;
	assign rs2 = inst.rs2;

	always_comb begin
		dispatch.valid = accept;
		dispatch.tag   = tail;
		dispatch.op    = inst.op;
		dispatch.rd    = inst.rd;
		dispatch.src_a = src_a;
		dispatch.src_b = src_b;
		dispatch.imm   = inst.imm;
	end

	//////////////////////////////////////////////////////////////////////
	// tail tag, one slot per accepted instruction
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tail <= '0;
		end else if (accept) begin
			tail <= next_tag(tail);
		end
	end

endmodule

// File: src/ooo_pkg.sv
package ooo_pkg;

	localparam int ROB_DEPTH = 8;
	localparam int TAG_W = $clog2(ROB_DEPTH);

	typedef logic [TAG_W-1:0] tag_t;

	// value awaited under tag while ready is low
	typedef struct packed {
		logic           ready;
		tag_t           tag;
		isa_pkg::data_t data;
	} operand_t;

	typedef struct packed {
		logic           valid;
		tag_t           tag;
		isa_pkg::data_t data;
	} cdb_t;

	typedef struct packed {
		logic              valid;
		tag_t              tag;
		isa_pkg::op_t      op;
		isa_pkg::reg_num_t rd;
		operand_t          src_a;
		operand_t          src_b;
		isa_pkg::imm_t     imm;
	} dispatch_t;

	typedef struct packed {
		logic              valid;
		isa_pkg::reg_num_t rd;
		isa_pkg::data_t    data;
	} commit_t;

	// fill a waiting operand from the result bus
	function automatic operand_t snoop(input operand_t o, input cdb_t cdb);
		operand_t r;
		r = o;
		if (!o.ready && cdb.valid && cdb.tag == o.tag) begin
			r.ready = 1'b1;
			r.data  = cdb.data;
		end
		return r;
	endfunction

	function automatic tag_t next_tag(input tag_t t);
		return (t == tag_t'(ROB_DEPTH - 1)) ? '0 : t + 1'b1;
	endfunction

endpackage

// File: src/isa_pkg.sv
package isa_pkg;

	localparam int NUM_REGS = 8;

	typedef logic [31:0] data_t;
	typedef logic [$clog2(NUM_REGS)-1:0] reg_num_t;
	typedef logic [15:0] imm_t;

	typedef enum logic [1:0] {
		OP_ADD  = 2'b00,
		OP_SUB  = 2'b01,
		OP_MOV  = 2'b10,
		OP_ADDI = 2'b11
	} op_t;

	// rs2 unused by MOV/ADDI, imm unused by ADD/SUB
	typedef struct packed {
		op_t      op;
		reg_num_t rd;
		reg_num_t rs1;
		reg_num_t rs2;
		imm_t     imm;
	} inst_t;

	function automatic data_t sext(input imm_t imm);
		return {{16{imm[15]}}, imm};
	endfunction

endpackage
